// File: src/uart_apb_settings.svh
`ifndef UART_APB_SETTINGS_SVH
`define UART_APB_SETTINGS_SVH

// Entries per FIFO, power of two
`define UART_APB_FIFO_DEPTH 8

// Clock cycles per serial bit, even
`define UART_CLKS_PER_BIT 8

`define UART_APB_BASE_ADDR 32'h0000_0000

// Register offsets from the base address
`define UART_REG_TXDATA 32'h0000_0000
`define UART_REG_RXDATA 32'h0000_0004
`define UART_REG_STATUS 32'h0000_0008

// Status register bit positions
`define UART_STAT_TX_FULL   0
`define UART_STAT_TX_EMPTY  1
`define UART_STAT_RX_EMPTY  2
`define UART_STAT_RX_FULL   3
`define UART_STAT_TX_BUSY   4
`define UART_STAT_OVERRUN   5
`define UART_STAT_FRAME_ERR 6

`endif

// File: src/uart_apb_pkg.sv
package uart_apb_pkg;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    // APB bus fields
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // RX FIFO entry, received byte plus its stop-bit status
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;  // Stop bit read as 0
    } uart_rx_entry_t;

endpackage

// File: src/uart_sync_fifo.sv
`timescale 1ns/1ps

`include "uart_apb_settings.svh"

module uart_sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `UART_APB_FIFO_DEPTH
) (
    input  logic uart_bit_clk,
    input  logic PRESETn,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic full,
    output logic empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge uart_bit_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge uart_bit_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];  // Head entry
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    // Producers and consumers must respect the flags
    push_not_full_a : assert property (
        @(posedge uart_bit_clk) disable iff (!PRESETn) push |-> !full
    ) else $error("push while FIFO full");

    pop_not_empty_a : assert property (
        @(posedge uart_bit_clk) disable iff (!PRESETn) pop |-> !empty
    ) else $error("pop while FIFO empty");

endmodule

// File: src/uart_tx_serializer.sv
`timescale 1ns/1ps

`include "uart_apb_settings.svh"

module uart_tx_serializer (
    input  logic                     uart_bit_clk,
    input  logic                     PRESETn,
    input  logic                     fifo_empty,
    input  uart_apb_pkg::uart_byte_t fifo_data,
    output logic                     fifo_pop,
    output logic                     busy,
    output logic                     tx
);
    import uart_apb_pkg::*;

    localparam int CPB   = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CPB - 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;   // Cycles within the current bit
    logic [2:0]       bit_idx;
    uart_byte_t       shift_reg;
    logic             bit_done;

    assign bit_done = (bit_cnt == LAST_CNT);

    // Pop again in the last stop cycle so frames run back to back
    assign fifo_pop = !fifo_empty && ((state == TX_IDLE) || ((state == TX_STOP) && bit_done));
    assign busy     = (state != TX_IDLE) || fifo_pop;

    always_ff @(posedge uart_bit_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;  // Line idles high
        end else if (fifo_pop) begin
            state   <= TX_START;
            bit_cnt <= '0;
            tx      <= 1'b0;  // Start bit
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        tx      <= shift_reg[0];  // LSB first
                    end else begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;  // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= shift_reg[0];
                        end
                    end else begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        state   <= TX_IDLE;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Next bit to send always sits in shift_reg[0]
    always_ff @(posedge uart_bit_clk) begin
        if (fifo_pop) begin
            shift_reg <= fifo_data;
        end else if (bit_done && ((state == TX_START) || (state == TX_DATA))) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    tx_idle_high_a : assert property (
        @(posedge uart_bit_clk) disable iff (!PRESETn) (state == TX_IDLE) |-> tx
    ) else $error("tx low while serializer idle");

endmodule

// File: src/uart_rx_deserializer.sv
`timescale 1ns/1ps

`include "uart_apb_settings.svh"

module uart_rx_deserializer (
    input  logic                         uart_bit_clk,
    input  logic                         PRESETn,
    input  logic                         rx,
    input  logic                         fifo_full,
    output logic                         fifo_push,
    output uart_apb_pkg::uart_rx_entry_t fifo_data,
    output logic                         overrun
);
    import uart_apb_pkg::*;

    localparam int CPB   = `UART_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CPB - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CPB / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;   // For falling edge detect
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_reg;
    logic             start_edge;
    logic             bit_done;
    logic             half_done;

    // Two-flop synchronizer, resets to the idle level
    always_ff @(posedge uart_bit_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // A falling edge also means the line was seen high first
    assign start_edge = rx_prev && !rx_sync;
    assign bit_done   = (bit_cnt == LAST_CNT);
    assign half_done  = (bit_cnt == HALF_CNT);

    always_ff @(posedge uart_bit_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            fifo_push <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            fifo_push <= 1'b0;
            overrun   <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_done) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // High at mid start bit means a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        state     <= RX_IDLE;
                        bit_cnt   <= '0;
                        fifo_push <= !fifo_full;
                        overrun   <= fifo_full;   // Frame dropped
                    end else begin
                        bit_cnt <= bit_cnt + CNT_W'(1);
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path, mid-bit samples enter from the top
    always_ff @(posedge uart_bit_clk) begin
        if ((state == RX_DATA) && bit_done) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if ((state == RX_STOP) && bit_done) begin
            fifo_data.data      <= shift_reg;
            fifo_data.frame_err <= !rx_sync;
        end
    end

    // Only this block fills the RX FIFO, so full cannot rise under a push
    push_not_full_a : assert property (
        @(posedge uart_bit_clk) disable iff (!PRESETn) fifo_push |-> !fifo_full
    ) else $error("RX push while FIFO full");

endmodule

// File: src/uart_apb_regs.sv
`timescale 1ns/1ps

`include "uart_apb_settings.svh"

module uart_apb_regs (
    input  logic                         uart_bit_clk,
    input  logic                         PRESETn,
    input  logic                         PSEL,
    input  logic                         PENABLE,
    input  logic                         PWRITE,
    input  uart_apb_pkg::apb_addr_t      PADDR,
    input  uart_apb_pkg::apb_data_t      PWDATA,
    output uart_apb_pkg::apb_data_t      PRDATA,
    output logic                         PREADY,
    output logic                         PSLVERR,
    output logic                         tx_push,
    output uart_apb_pkg::uart_byte_t     tx_push_data,
    input  logic                         tx_full,
    input  logic                         tx_empty,
    input  logic                         tx_busy,
    output logic                         rx_pop,
    input  uart_apb_pkg::uart_rx_entry_t rx_pop_data,
    input  logic                         rx_empty,
    input  logic                         rx_full,
    input  logic                         rx_overrun
);
    import uart_apb_pkg::*;

    localparam apb_addr_t TXDATA_ADDR = `UART_APB_BASE_ADDR + `UART_REG_TXDATA;
    localparam apb_addr_t RXDATA_ADDR = `UART_APB_BASE_ADDR + `UART_REG_RXDATA;
    localparam apb_addr_t STATUS_ADDR = `UART_APB_BASE_ADDR + `UART_REG_STATUS;

    logic      wait_q;       // High in the second access cycle
    logic      overrun_q;
    logic      sel_tx;
    logic      sel_rx;
    logic      sel_stat;
    logic      slv_err;
    logic      ovr_clr;
    apb_data_t status;
    apb_data_t rd_data;

    // One wait state, then ready
    always_ff @(posedge uart_bit_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            wait_q <= 1'b0;
        end else if (PSEL && PENABLE && !wait_q) begin
            wait_q <= 1'b1;
        end else begin
            wait_q <= 1'b0;
        end
    end

    assign PREADY = wait_q;

    assign sel_tx   = (PADDR == TXDATA_ADDR);
    assign sel_rx   = (PADDR == RXDATA_ADDR);
    assign sel_stat = (PADDR == STATUS_ADDR);

    // TXDATA is write only, RXDATA read only
    always_comb begin
        if (sel_tx) begin
            slv_err = !PWRITE || tx_full;
        end else if (sel_rx) begin
            slv_err = PWRITE || rx_empty;
        end else if (sel_stat) begin
            slv_err = 1'b0;
        end else begin
            slv_err = 1'b1;  // Unmapped
        end
    end

    always_comb begin
        status                       = '0;
        status[`UART_STAT_TX_FULL]   = tx_full;
        status[`UART_STAT_TX_EMPTY]  = tx_empty;
        status[`UART_STAT_RX_EMPTY]  = rx_empty;
        status[`UART_STAT_RX_FULL]   = rx_full;
        status[`UART_STAT_TX_BUSY]   = tx_busy;
        status[`UART_STAT_OVERRUN]   = overrun_q;
        // Head entry is stale while empty
        status[`UART_STAT_FRAME_ERR] = !rx_empty && rx_pop_data.frame_err;
    end

    always_comb begin
        rd_data = '0;
        if (!PWRITE && sel_rx && !rx_empty) begin
            rd_data = apb_data_t'(rx_pop_data.data);
        end else if (!PWRITE && sel_stat) begin
            rd_data = status;
        end
    end

    assign PRDATA  = PREADY ? rd_data : '0;
    assign PSLVERR = PREADY && slv_err;

    // Side effects land on the edge that ends the transfer
    assign tx_push      = PREADY && PWRITE && sel_tx && !tx_full;
    assign tx_push_data = PWDATA[7:0];
    assign rx_pop       = PREADY && !PWRITE && sel_rx && !rx_empty;
    assign ovr_clr      = PREADY && PWRITE && sel_stat && PWDATA[`UART_STAT_OVERRUN];

    always_ff @(posedge uart_bit_clk or negedge PRESETn) begin
        if (!PRESETn) begin
            overrun_q <= 1'b0;
        end else if (rx_overrun) begin
            overrun_q <= 1'b1;  // New drop wins over a clear
        end else if (ovr_clr) begin
            overrun_q <= 1'b0;
        end
    end

    // Ready only inside an access phase driven by the master
    pready_in_access_a : assert property (
        @(posedge uart_bit_clk) disable iff (!PRESETn) PREADY |-> (PSEL && PENABLE)
    ) else $error("PREADY outside an APB access phase");

endmodule

// File: src/uart_apb.sv
`timescale 1ns/1ps

`include "uart_apb_settings.svh"

module uart_apb (
    input  logic                    uart_bit_clk,
    input  logic                    PRESETn,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  uart_apb_pkg::apb_addr_t PADDR,
    input  uart_apb_pkg::apb_data_t PWDATA,
    output uart_apb_pkg::apb_data_t PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,
    output logic                    tx,
    input  logic                    rx
);
    import uart_apb_pkg::*;

    // TX path
    logic           tx_push;
    uart_byte_t     tx_push_data;
    logic           tx_pop;
    uart_byte_t     tx_pop_data;
    logic           tx_full;
    logic           tx_empty;
    logic           tx_busy;

    // RX path
    logic           rx_push;
    uart_rx_entry_t rx_push_data;
    logic           rx_pop;
    uart_rx_entry_t rx_pop_data;
    logic           rx_full;
    logic           rx_empty;
    logic           rx_overrun;

    uart_apb_regs regs_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PWRITE       (PWRITE),
        .PADDR        (PADDR),
        .PWDATA       (PWDATA),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .PSLVERR      (PSLVERR),
        .tx_push      (tx_push),
        .tx_push_data (tx_push_data),
        .tx_full      (tx_full),
        .tx_empty     (tx_empty),
        .tx_busy      (tx_busy),
        .rx_pop       (rx_pop),
        .rx_pop_data  (rx_pop_data),
        .rx_empty     (rx_empty),
        .rx_full      (rx_full),
        .rx_overrun   (rx_overrun)
    );

    uart_sync_fifo #(
        .T     (uart_byte_t),
        .DEPTH (`UART_APB_FIFO_DEPTH)
    ) tx_fifo_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn),
        .push         (tx_push),
        .push_data    (tx_push_data),
        .pop          (tx_pop),
        .pop_data     (tx_pop_data),
        .full         (tx_full),
        .empty        (tx_empty)
    );

    uart_sync_fifo #(
        .T     (uart_rx_entry_t),
        .DEPTH (`UART_APB_FIFO_DEPTH)
    ) rx_fifo_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn),
        .push         (rx_push),
        .push_data    (rx_push_data),
        .pop          (rx_pop),
        .pop_data     (rx_pop_data),
        .full         (rx_full),
        .empty        (rx_empty)
    );

    uart_tx_serializer tx_ser_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn),
        .fifo_empty   (tx_empty),
        .fifo_data    (tx_pop_data),
        .fifo_pop     (tx_pop),
        .busy         (tx_busy),
        .tx           (tx)
    );

    uart_rx_deserializer rx_deser_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn),
        .rx           (rx),
        .fifo_full    (rx_full),
        .fifo_push    (rx_push),
        .fifo_data    (rx_push_data),
        .overrun      (rx_overrun)
    );

endmodule

// File: verification/uart_apb_tb_clock.sv
`timescale 1ns/1ps

module uart_apb_tb_clock (
    output logic uart_bit_clk,
    output logic PRESETn
);

    // 10 ns period
    initial begin
        uart_bit_clk = 1'b0;
        forever #5 uart_bit_clk = ~uart_bit_clk;
    end

    initial begin
        PRESETn = 1'b0;
        repeat (10) @(posedge uart_bit_clk);
        PRESETn <= 1'b1;  // Release on a rising edge
    end

endmodule

// File: verification/uart_apb_tb.sv
`timescale 1ns/1ps

`include "uart_apb_settings.svh"

module uart_apb_tb;
    import uart_apb_pkg::*;

    localparam int DEPTH          = `UART_APB_FIFO_DEPTH;
    localparam int CPB            = `UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES   = 10 * CPB;
    localparam int READY_TIMEOUT  = 8;
    localparam int RESET_TIMEOUT  = 50;

    localparam apb_data_t TXDATA = `UART_REG_TXDATA;
    localparam apb_data_t RXDATA = `UART_REG_RXDATA;
    localparam apb_data_t STATUS = `UART_REG_STATUS;
    localparam apb_data_t UNMAPPED = 32'h0000_000C;

    // Status bit masks
    localparam apb_data_t ST_TX_FULL   = 32'd1 << `UART_STAT_TX_FULL;
    localparam apb_data_t ST_TX_EMPTY  = 32'd1 << `UART_STAT_TX_EMPTY;
    localparam apb_data_t ST_RX_EMPTY  = 32'd1 << `UART_STAT_RX_EMPTY;
    localparam apb_data_t ST_RX_FULL   = 32'd1 << `UART_STAT_RX_FULL;
    localparam apb_data_t ST_TX_BUSY   = 32'd1 << `UART_STAT_TX_BUSY;
    localparam apb_data_t ST_OVERRUN   = 32'd1 << `UART_STAT_OVERRUN;
    localparam apb_data_t ST_FRAME_ERR = 32'd1 << `UART_STAT_FRAME_ERR;
    localparam apb_data_t ST_IDLE      = ST_TX_EMPTY | ST_RX_EMPTY;

    // Table operation kinds
    localparam logic [1:0] OP_WR      = 2'd0;
    localparam logic [1:0] OP_RD      = 2'd1;
    localparam logic [1:0] OP_RD_ERR  = 2'd2;  // Only PSLVERR is checked
    localparam logic [1:0] OP_WAIT_RX = 2'd3;

    typedef struct packed {
        logic [1:0] op;
        apb_data_t  offset;
        apb_data_t  wdata;
        apb_data_t  rdata;
        logic       err;
    } stim_row_t;

    logic       uart_bit_clk;
    logic       PRESETn;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       tx;
    logic       rx;
    logic       loopback;
    logic       ser_line;
    int         cycle_cnt;
    logic [31:0] lcg_state;
    stim_row_t  stim_table[$];
    uart_byte_t sent[$];
    uart_byte_t byte_val;
    apb_data_t  rdata;
    apb_data_t  st;
    logic       err;
    int         wait_cnt;

    uart_apb_tb_clock clock_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn)
    );

    uart_apb uart_apb_inst (
        .uart_bit_clk (uart_bit_clk),
        .PRESETn      (PRESETn),
        .PSEL         (psel),
        .PENABLE      (penable),
        .PWRITE       (pwrite),
        .PADDR        (paddr),
        .PWDATA       (pwdata),
        .PRDATA       (prdata),
        .PREADY       (pready),
        .PSLVERR      (pslverr),
        .tx           (tx),
        .rx           (rx)
    );

    assign rx = loopback ? tx : ser_line;  // Loopback or driven line

    always @(posedge uart_bit_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_byte(input string name, input uart_byte_t actual,
                              input uart_byte_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input apb_data_t actual,
                              input apb_data_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    function automatic uart_byte_t next_rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];  // Upper bits are the most random
    endfunction

    // Setup cycle, then access cycles until PREADY
    task automatic apb_xfer(input logic write, input apb_data_t offset, input apb_data_t wdata,
                            output apb_data_t data, output logic slv_err);
        int waited;
        @(posedge uart_bit_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= `UART_APB_BASE_ADDR + offset;
        pwdata  <= wdata;
        @(posedge uart_bit_clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge uart_bit_clk);
        while (!pready) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                $display("PREADY never came high during an APB transfer");
                abort_run();
            end
            @(negedge uart_bit_clk);
        end
        // Exactly one wait state is expected
        if (waited != 1) begin
            $display("PREADY did not come high in the second access cycle");
            abort_run();
        end
        data    = prdata;
        slv_err = pslverr;
        @(posedge uart_bit_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_data_t offset, input apb_data_t wdata,
                             output logic slv_err);
        apb_data_t unused;
        apb_xfer(1'b1, offset, wdata, unused, slv_err);
    endtask

    task automatic apb_read(input apb_data_t offset, output apb_data_t data,
                            output logic slv_err);
        apb_xfer(1'b0, offset, 32'h0, data, slv_err);
    endtask

    // Polls STATUS until the masked bits match
    task automatic poll_status(input apb_data_t mask, input apb_data_t value,
                               input int max_cycles, input string what,
                               output apb_data_t status);
        int   start;
        logic slv_err;
        start = cycle_cnt;
        apb_read(STATUS, status, slv_err);
        check_err("PSLVERR", slv_err, 1'b0);
        while ((status & mask) !== value) begin
            if (cycle_cnt - start > max_cycles) begin
                $display("Timed out waiting for %s", what);
                abort_run();
            end
            apb_read(STATUS, status, slv_err);
            check_err("PSLVERR", slv_err, 1'b0);
        end
    endtask

    task automatic read_rx_byte(input uart_byte_t expected);
        apb_data_t data;
        logic      slv_err;
        apb_read(RXDATA, data, slv_err);
        check_err("PSLVERR", slv_err, 1'b0);
        check_byte("RXDATA", data[7:0], expected);
        check_data("PRDATA", data & 32'hFFFF_FF00, 32'h0);
    endtask

    task automatic drive_serial_bit(input logic level);
        @(posedge uart_bit_clk);
        ser_line <= level;
        repeat (CPB - 1) @(posedge uart_bit_clk);
    endtask

    task automatic send_frame(input uart_byte_t data, input logic bad_stop);
        drive_serial_bit(1'b0);  // Start
        for (int i = 0; i < 8; i++) begin
            drive_serial_bit(data[i]);
        end
        drive_serial_bit(!bad_stop);
        drive_serial_bit(1'b1);  // Idle bit lets the receiver re-arm
    endtask

    task automatic add_row(input logic [1:0] op, input apb_data_t offset,
                           input apb_data_t wdata, input apb_data_t exp_data,
                           input logic exp_err);
        stim_row_t row;
        row.op     = op;
        row.offset = offset;
        row.wdata  = wdata;
        row.rdata  = exp_data;
        row.err    = exp_err;
        stim_table.push_back(row);
    endtask

    task automatic load_table();
        uart_byte_t bytes[4];
        bytes = '{8'h55, 8'hA3, 8'h00, 8'hFF};
        add_row(OP_RD, STATUS, 32'h0, ST_IDLE, 1'b0);
        foreach (bytes[i]) begin
            add_row(OP_WR, TXDATA, {24'h0, bytes[i]}, 32'h0, 1'b0);
            add_row(OP_WAIT_RX, STATUS, 32'h0, 32'h0, 1'b0);
            add_row(OP_RD, RXDATA, 32'h0, {24'h0, bytes[i]}, 1'b0);
        end
        // Each refused access must leave STATUS alone
        add_row(OP_RD, STATUS, 32'h0, ST_IDLE, 1'b0);
        add_row(OP_RD_ERR, UNMAPPED, 32'h0, 32'h0, 1'b1);
        add_row(OP_RD, STATUS, 32'h0, ST_IDLE, 1'b0);
        add_row(OP_RD_ERR, TXDATA, 32'h0, 32'h0, 1'b1);
        add_row(OP_RD, STATUS, 32'h0, ST_IDLE, 1'b0);
        add_row(OP_WR, RXDATA, 32'h12, 32'h0, 1'b1);
        add_row(OP_RD, STATUS, 32'h0, ST_IDLE, 1'b0);
        add_row(OP_RD_ERR, RXDATA, 32'h0, 32'h0, 1'b1);
        add_row(OP_RD, STATUS, 32'h0, ST_IDLE, 1'b0);
    endtask

    task automatic run_row(input stim_row_t row);
        apb_data_t data;
        apb_data_t status;
        logic      slv_err;
        case (row.op)
            OP_WR: begin
                apb_write(row.offset, row.wdata, slv_err);
                check_err("PSLVERR", slv_err, row.err);
            end
            OP_RD: begin
                apb_read(row.offset, data, slv_err);
                check_err("PSLVERR", slv_err, row.err);
                check_data("PRDATA", data, row.rdata);
            end
            OP_RD_ERR: begin
                apb_read(row.offset, data, slv_err);
                check_err("PSLVERR", slv_err, row.err);
            end
            default: begin
                poll_status(ST_RX_EMPTY, 32'h0, 2 * FRAME_CYCLES, "received byte", status);
                check_data("STATUS frame_err", status & ST_FRAME_ERR, 32'h0);
            end
        endcase
    endtask

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        loopback  = 1'b0;
        ser_line  = 1'b1;
        cycle_cnt = 0;
        lcg_state = 32'd97239;

        wait_cnt = 0;
        while (PRESETn !== 1'b1) begin
            wait_cnt++;
            if (wait_cnt > RESET_TIMEOUT) begin
                $display("Reset was never released");
                abort_run();
            end
            @(posedge uart_bit_clk);
        end

        // Reset state
        @(negedge uart_bit_clk);
        check_err("tx", tx, 1'b1);
        check_err("PREADY", pready, 1'b0);
        check_err("PSLVERR", pslverr, 1'b0);
        check_data("PRDATA", prdata, 32'h0);

        // Table rows run loopback bytes and then refused accesses
        load_table();
        @(posedge uart_bit_clk);
        loopback <= 1'b1;
        foreach (stim_table[i]) begin
            run_row(stim_table[i]);
        end

        // Random bytes in a burst so frames run back to back
        for (int i = 0; i < DEPTH / 2; i++) begin
            byte_val = next_rand_byte();
            sent.push_back(byte_val);
            apb_write(TXDATA, {24'h0, byte_val}, err);
            check_err("PSLVERR", err, 1'b0);
        end
        while (sent.size() > 0) begin
            poll_status(ST_RX_EMPTY, 32'h0, 2 * FRAME_CYCLES, "looped back byte", st);
            check_data("STATUS frame_err", st & ST_FRAME_ERR, 32'h0);
            read_rx_byte(sent.pop_front());
        end
        poll_status(32'hFFFF_FFFF, ST_IDLE, 2 * FRAME_CYCLES, "idle after loopback", st);

        // TX back-pressure where the first byte leaves for the serializer at once
        @(posedge uart_bit_clk);
        loopback <= 1'b0;
        for (int i = 0; i < DEPTH + 2; i++) begin
            apb_write(TXDATA, {24'h0, next_rand_byte()}, err);
            check_err("PSLVERR", err, (i == DEPTH + 1));
        end
        apb_read(STATUS, rdata, err);
        check_err("PSLVERR", err, 1'b0);
        check_data("STATUS", rdata, ST_TX_FULL | ST_TX_BUSY | ST_RX_EMPTY);
        poll_status(ST_TX_EMPTY | ST_TX_BUSY, ST_TX_EMPTY, (DEPTH + 2) * FRAME_CYCLES,
                    "TX FIFO to drain", st);
        check_data("STATUS", st, ST_IDLE);

        // Framing error on a bad stop bit
        send_frame(8'h3C, 1'b1);
        poll_status(ST_RX_EMPTY, 32'h0, 2 * FRAME_CYCLES, "bad-stop frame", st);
        check_data("STATUS", st, ST_TX_EMPTY | ST_FRAME_ERR);
        read_rx_byte(8'h3C);
        apb_read(STATUS, rdata, err);
        check_err("PSLVERR", err, 1'b0);
        check_data("STATUS", rdata, ST_IDLE);

        // Overrun with one frame more than the RX FIFO holds
        for (int i = 0; i < DEPTH + 1; i++) begin
            byte_val = next_rand_byte();
            sent.push_back(byte_val);
            send_frame(byte_val, 1'b0);
        end
        poll_status(ST_OVERRUN, ST_OVERRUN, 2 * FRAME_CYCLES, "overrun flag", st);
        check_data("STATUS", st, ST_TX_EMPTY | ST_RX_FULL | ST_OVERRUN);
        for (int i = 0; i < DEPTH; i++) begin
            read_rx_byte(sent.pop_front());
        end
        apb_read(STATUS, rdata, err);
        check_err("PSLVERR", err, 1'b0);
        check_data("STATUS", rdata, ST_IDLE | ST_OVERRUN);
        apb_write(STATUS, ST_OVERRUN, err);
        check_err("PSLVERR", err, 1'b0);
        apb_read(STATUS, rdata, err);
        check_err("PSLVERR", err, 1'b0);
        check_data("STATUS", rdata, ST_IDLE);

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: uart_apb.f
+incdir+src
src/uart_apb_pkg.sv
src/uart_sync_fifo.sv
src/uart_tx_serializer.sv
src/uart_rx_deserializer.sv
src/uart_apb_regs.sv
src/uart_apb.sv
verification/uart_apb_tb_clock.sv
verification/uart_apb_tb.sv
